// ==== hdl/hd44780_cfg.svh ====
//**********************************************************************
// timing and width constants for the HD44780 4-bit LCD driver
// included by the RTL and the testbench; all times are in clock ticks
//**********************************************************************

`ifndef HD44780_CFG_SVH
`define HD44780_CFG_SVH

//**********************************************************************
// nybble sender enable-cycle timing
//**********************************************************************

// these are the simulation-sized values
// for the board, work each one out from the datasheet times and the system
// clock: TAS covers 60 ns, PWEH covers 450 ns, and the whole cycle must be
// at least 1000 ns (TCYCE) plus the setup time

// ticks from latching rs and data to raising enable (address setup)
`define H4NS_TICKS_TAS (2)

// ticks that enable stays high
`define H4NS_TICKS_PWEH (5)

// total length of one enable cycle: setup, pulse, hold and padding
// it has to stay larger than TAS plus PWEH so there is some hold time
`define H4NS_COUNT_TOP (12)

// width of the sender down-counter, must hold H4NS_COUNT_TOP
`define H4NS_COUNT_BITS (4)

//**********************************************************************
// alive LED
//**********************************************************************

// width of the free-running alive counter
// small for simulation, around 25 on the board for a visible blink
`define H4_ALIVE_BITS (6)

`endif

// ==== hdl/hd44780_pkg.sv ====
//**********************************************************************
// shared struct types for the HD44780 driver
// referred to by scoped name from the RTL, testbench and checker
//**********************************************************************

`default_nettype none

package hd44780_pkg;

    //******************************************************************
    // sequencer to sender
    //******************************************************************

    // one nybble request handed to the nybble sender
    // rs goes straight to the LCD register-select pin
    typedef struct packed {
        logic       rs;
        logic [3:0] data;
    } nybble_req_t;

    //******************************************************************
    // LCD-facing pins
    //******************************************************************

    // only the upper four LCD data pins are used in 4-bit mode
    // so data[3] drives D7 and data[0] drives D4
    // R/W is not here, the board ties it low since this driver only writes
    typedef struct packed {
        logic       rs;
        logic       e;
        logic [3:0] data;
    } lcd_pins_t;

endpackage

`default_nettype wire

// ==== hdl/hd44780_nybble_sender.sv ====
//**********************************************************************
// sends one nybble to the LCD in a single timed enable cycle
// pulse i_start while o_busy is low; rs and data stay put until next start
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "hd44780_cfg.svh"

module hd44780_nybble_sender (
    input  wire                      CLK_I,
    input  wire                      RST_I,
    input  wire                      i_start,
    input  wire hd44780_pkg::nybble_req_t i_req,
    output logic                     o_busy,
    output hd44780_pkg::lcd_pins_t   o_lcd
);

    //******************************************************************
    // counter marks
    //******************************************************************

    localparam int cnt_w = `H4NS_COUNT_BITS;

    // value loaded on an accepted start, then counted down to zero
    localparam logic [cnt_w-1:0] cnt_top = cnt_w'(`H4NS_COUNT_TOP);

    // counter values right after the edges where enable changes
    // enable rises TAS edges after the start edge
    localparam logic [cnt_w-1:0] e_rise_mark = cnt_w'(`H4NS_COUNT_TOP - `H4NS_TICKS_TAS);
    // and falls PWEH edges after that
    localparam logic [cnt_w-1:0] e_fall_mark =
        cnt_w'(`H4NS_COUNT_TOP - `H4NS_TICKS_TAS - `H4NS_TICKS_PWEH);

    //******************************************************************
    // down-counter
    //******************************************************************

    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] cnt_nxt;

    // value the counter takes on this edge while it is running
    // comparing against this instead of cnt keeps the marks readable
    assign cnt_nxt = cnt - 1'b1;

    // timeline with the simulation values, edge 0 is the start edge
    //   edge 0   rs and data latched, cnt loaded with 12, busy set
    //   edge 2   cnt goes to 10, enable rises
    //   edge 7   cnt goes to 5, enable falls and the LCD samples data
    //   edge 12  cnt reaches 0, the rest of the cycle was hold and padding
    //   edge 13  busy drops, ready for the next nybble
    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            cnt    <= '0;
            o_busy <= 1'b0;
            o_lcd  <= '0;
        end else if (i_start && !o_busy) begin
            // new nybble, register the pins so the LCD never sees the
            // request lines move while the cycle is in progress
            o_lcd.rs   <= i_req.rs;
            o_lcd.data <= i_req.data;
            o_lcd.e    <= 1'b0;
            cnt        <= cnt_top;
            o_busy     <= 1'b1;
        end else if (cnt != '0) begin
            cnt <= cnt_nxt;
            // enable goes high only once setup time has passed
            if (cnt_nxt == e_rise_mark) begin
                o_lcd.e <= 1'b1;
            end else if (cnt_nxt == e_fall_mark) begin
                o_lcd.e <= 1'b0;
            end
        end else begin
            // counter at zero, the cycle is over or nothing is running
            // a start that came in while busy was ignored and lands here
            o_busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hd44780_byte_sequencer.sv ====
//**********************************************************************
// turns an accepted byte into two nybble requests, upper nybble first
// strobe i_stb for one cycle while busy is low; i_rs and i_data sampled then
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module hd44780_byte_sequencer (
    input  wire                        CLK_I,
    input  wire                        RST_I,
    input  wire                        i_stb,
    input  wire                        i_rs,
    input  wire [7:0]                  i_data,
    input  wire                        i_ns_busy,
    output logic                       o_ns_start,
    output hd44780_pkg::nybble_req_t   o_ns_req,
    output logic                       o_busy
);

    //******************************************************************
    // state machine
    //******************************************************************

    // send states launch a nybble once the sender is idle
    // wait states drop the start pulse and then wait out the sender
    typedef enum logic [2:0] {
        st_idle,
        st_send_hi,
        st_wait_hi,
        st_send_lo,
        st_wait_lo
    } state_t;

    state_t state;

    // copy of the accepted byte so the host may change its lines at once
    logic [7:0] shadow_data;
    logic       shadow_rs;

    logic accept;

    // the sender busy test matters right after a transfer, when this
    // machine is already idle but the lower nybble may still be going out
    assign accept = (state == st_idle) && i_stb && !i_ns_busy;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state      <= st_idle;
            o_busy     <= 1'b0;
            o_ns_start <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    o_ns_start <= 1'b0;
                    if (accept) begin
                        o_busy <= 1'b1;
                        state  <= st_send_hi;
                    end
                end

                st_send_hi: begin
                    if (!i_ns_busy) begin
                        o_ns_start <= 1'b1;
                        state      <= st_wait_hi;
                    end
                end

                st_wait_hi: begin
                    // the sender takes the pulse on this edge, so its busy
                    // is still low here and must not be trusted yet
                    if (o_ns_start) begin
                        o_ns_start <= 1'b0;
                    end else if (!i_ns_busy) begin
                        state <= st_send_lo;
                    end
                end

                st_send_lo: begin
                    if (!i_ns_busy) begin
                        o_ns_start <= 1'b1;
                        state      <= st_wait_lo;
                    end
                end

                st_wait_lo: begin
                    // same hand-off as for the upper nybble
                    if (o_ns_start) begin
                        o_ns_start <= 1'b0;
                    end else if (!i_ns_busy) begin
                        o_busy <= 1'b0;
                        state  <= st_idle;
                    end
                end

                default: begin
                    o_busy     <= 1'b0;
                    o_ns_start <= 1'b0;
                    state      <= st_idle;
                end
            endcase
        end
    end

    //******************************************************************
    // byte shadow and nybble request
    //******************************************************************

    // the request only has to be valid on the edge where start is high,
    // which is always the edge after a send state
    always_ff @(posedge CLK_I) begin
        if (accept) begin
            shadow_data <= i_data;
            shadow_rs   <= i_rs;
        end
        if (state == st_send_hi) begin
            o_ns_req.rs   <= shadow_rs;
            o_ns_req.data <= shadow_data[7:4];
        end else if (state == st_send_lo) begin
            o_ns_req.rs   <= shadow_rs;
            o_ns_req.data <= shadow_data[3:0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hd44780_controller.sv ====
//**********************************************************************
// top of the write-only HD44780 driver in 4-bit mode, plus alive LED
// host strobes a byte while o_busy is low and waits for o_busy to fall
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "hd44780_cfg.svh"

module hd44780_controller (
    input  wire                      CLK_I,
    input  wire                      RST_I,
    input  wire                      i_stb,
    input  wire                      i_rs,
    input  wire [7:0]                i_data,
    output logic                     o_busy,
    output logic                     o_alive_led,
    output hd44780_pkg::lcd_pins_t   o_lcd
);

    //******************************************************************
    // byte sequencer and nybble sender
    //******************************************************************

    logic                     ns_start;
    logic                     ns_busy;
    logic                     seq_busy;
    hd44780_pkg::nybble_req_t ns_req;

    hd44780_byte_sequencer i_byte_sequencer (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .i_stb      (i_stb),
        .i_rs       (i_rs),
        .i_data     (i_data),
        .i_ns_busy  (ns_busy),
        .o_ns_start (ns_start),
        .o_ns_req   (ns_req),
        .o_busy     (seq_busy)
    );

    hd44780_nybble_sender i_nybble_sender (
        .CLK_I   (CLK_I),
        .RST_I   (RST_I),
        .i_start (ns_start),
        .i_req   (ns_req),
        .o_busy  (ns_busy),
        .o_lcd   (o_lcd)
    );

    // the sender's busy covers the tail of the lower nybble after the
    // sequencer has already gone back to idle
    assign o_busy = seq_busy | ns_busy;

    //******************************************************************
    // alive LED
    //******************************************************************

    logic [`H4_ALIVE_BITS-1:0] alive_cnt;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            alive_cnt <= '0;
        end else begin
            alive_cnt <= alive_cnt + 1'b1;
        end
    end

    // LED lit for the first half period after reset, then blinks evenly
    assign o_alive_led = ~alive_cnt[`H4_ALIVE_BITS-1];

endmodule

`default_nettype wire

// ==== tb/hd44780_checker.sv ====
//**********************************************************************
// LCD bus assertions, bound into the controller top level
// checks busy coverage, pin stability and the enable pulse width
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "hd44780_cfg.svh"

module hd44780_checker (
    input wire                         CLK_I,
    input wire                         RST_I,
    input wire                         i_busy,
    input wire hd44780_pkg::lcd_pins_t i_lcd
);

    // number of consecutive cycles that enable has been high so far
    int e_high_cnt;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            e_high_cnt <= 0;
        end else if (i_lcd.e) begin
            e_high_cnt <= e_high_cnt + 1;
        end else begin
            e_high_cnt <= 0;
        end
    end

    //******************************************************************
    // assertions
    //******************************************************************

    // an enable pulse is always part of a transfer the host can see
    busy_during_enable: assert property (
        @(posedge CLK_I) disable iff (RST_I) i_lcd.e |-> i_busy
    ) else $error("enable high while o_busy is low");

    // the LCD samples on the falling edge, so rs and data must not move
    // at any point of the pulse, the falling edge included
    pins_stable_during_enable: assert property (
        @(posedge CLK_I) disable iff (RST_I)
        i_lcd.e |=> ($stable(i_lcd.rs) && $stable(i_lcd.data))
    ) else $error("rs or data changed while enable was high");

    enable_width_limit: assert property (
        @(posedge CLK_I) disable iff (RST_I) e_high_cnt <= `H4NS_TICKS_PWEH
    ) else $error("enable stayed high longer than the pulse width");

endmodule

bind hd44780_controller hd44780_checker i_hd44780_checker (
    .CLK_I  (CLK_I),
    .RST_I  (RST_I),
    .i_busy (o_busy),
    .i_lcd  (o_lcd)
);

`default_nettype wire

// ==== tb/hd44780_clkgen.sv ====
//**********************************************************************
// testbench clock and reset source, 40 ns period
// reset is held for the first 8 rising edges and released on a falling edge
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module hd44780_clkgen (
    output logic o_clk,
    output logic o_rst
);

    localparam int half_period_ns = 20;
    localparam int reset_cycles   = 8;

    initial begin
        o_clk = 1'b0;
        o_rst = 1'b1;
    end

    always #(half_period_ns) o_clk = ~o_clk;

    // release on a falling edge, like every other DUT input
    // processes woken by that same edge still see reset high
    initial begin
        repeat (reset_cycles) @(posedge o_clk);
        @(negedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/hd44780_tb.sv ====
//**********************************************************************
// testbench for the HD44780 driver: LFSR bytes, busy strobes, LCD model
// run as top; it ends by itself, through the cycle limit at the latest
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "hd44780_cfg.svh"

module hd44780_tb;

    localparam int num_bytes = 40;
    localparam int led_half  = 1 << (`H4_ALIVE_BITS - 1);
    // two full LED periods
    localparam int led_span  = 4 * led_half;
    // worst case per byte is two enable cycles plus sequencing and the gap
    localparam int cycle_limit = num_bytes * (2 * `H4NS_COUNT_TOP + 16) + 8 + led_span;

    logic                   CLK_I;
    logic                   RST_I;
    logic                   stb;
    logic                   rs;
    logic [7:0]             data;
    logic                   busy;
    logic                   alive_led;
    hd44780_pkg::lcd_pins_t lcd;

    logic [31:0] lfsr;
    logic [8:0]  exp_q[$];
    int          value_errors;
    int          other_errors;
    int          accepted;
    int          rejected;
    int          pulses;
    int          cycle_cnt;
    int          since_rst;
    logic        led_done;

    hd44780_clkgen i_clkgen (
        .o_clk (CLK_I),
        .o_rst (RST_I)
    );

    hd44780_controller i_hd44780_controller (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .i_stb       (stb),
        .i_rs        (rs),
        .i_data      (data),
        .o_busy      (busy),
        .o_alive_led (alive_led),
        .o_lcd       (lcd)
    );

    //******************************************************************
    // random numbers
    //******************************************************************

    // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step for every bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic finish_run();
        $display("error counts: %0d wrong values, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    //******************************************************************
    // host side
    //******************************************************************

    // writes one random byte, then tries a second strobe that must be dropped
    task automatic send_byte();
        logic [31:0] v;
        logic [7:0]  b;
        logic        r;
        while (busy) @(negedge CLK_I);
        draw_bits(8, v);
        b = v[7:0];
        draw_bits(1, v);
        r = v[0];
        // busy is low here and stays so until the next rising edge
        stb  = 1'b1;
        rs   = r;
        data = b;
        exp_q.push_back({r, b});
        accepted++;
        @(negedge CLK_I);
        stb = 1'b0;
        if (busy !== 1'b1) begin
            $display("Fail o_busy: expected %h, got %h", 1'b1, busy);
            value_errors++;
        end
        draw_bits(3, v);
        repeat (v[2:0]) @(negedge CLK_I);
        if (busy) begin
            draw_bits(9, v);
            stb  = 1'b1;
            rs   = v[8];
            data = v[7:0];
            @(negedge CLK_I);
            stb = 1'b0;
            rejected++;
        end
        while (busy) @(negedge CLK_I);
        // idle gap before the next byte
        draw_bits(3, v);
        repeat (v[2:0]) @(negedge CLK_I);
    endtask

    initial begin
        stb          = 1'b0;
        rs           = 1'b0;
        data         = 8'h00;
        lfsr         = 32'hccdb6d3d;
        value_errors = 0;
        other_errors = 0;
        accepted     = 0;
        rejected     = 0;
        @(negedge CLK_I);
        while (RST_I) @(negedge CLK_I);
        // leave the first cycle after reset quiet for the reset check
        repeat (2) @(negedge CLK_I);
        for (int n = 0; n < num_bytes; n++) begin
            send_byte();
        end
        while (busy || !led_done) @(negedge CLK_I);
        if (exp_q.size() != 0) begin
            $display("%0d accepted bytes never showed up on the LCD bus", exp_q.size());
            other_errors++;
        end
        if (pulses != 2 * accepted) begin
            $display("Fail enable pulse count: expected %h, got %h", 2 * accepted, pulses);
            value_errors++;
        end
        $display("%0d bytes accepted, %0d strobes sent while busy", accepted, rejected);
        finish_run();
    end

    //******************************************************************
    // LCD bus model
    //******************************************************************

    int         e_len;
    logic       e_prev;
    logic       have_hi;
    logic       hi_rs;
    logic [3:0] hi_data;
    logic [8:0] exp_byte;

    initial begin
        e_len   = 0;
        e_prev  = 1'b0;
        have_hi = 1'b0;
        pulses  = 0;
    end

    // the LCD latches rs and data on the falling edge of enable, the
    // first nybble of a pair is the upper one
    always @(negedge CLK_I) begin
        if (!RST_I) begin
            if (lcd.e) begin
                e_len++;
            end else if (e_prev) begin
                pulses++;
                if (e_len != `H4NS_TICKS_PWEH) begin
                    $display("Fail enable width: expected %h, got %h", `H4NS_TICKS_PWEH, e_len);
                    value_errors++;
                end
                e_len = 0;
                if (!have_hi) begin
                    hi_rs   = lcd.rs;
                    hi_data = lcd.data;
                    have_hi = 1'b1;
                end else if (exp_q.size() == 0) begin
                    $display("a byte went out on the LCD bus with no accepted request");
                    other_errors++;
                    have_hi = 1'b0;
                end else begin
                    have_hi  = 1'b0;
                    exp_byte = exp_q.pop_front();
                    if ({hi_data, lcd.data} !== exp_byte[7:0]) begin
                        $display("Fail lcd.data: expected %h, got %h", exp_byte[7:0],
                                 {hi_data, lcd.data});
                        value_errors++;
                    end
                    if (hi_rs !== exp_byte[8] || lcd.rs !== exp_byte[8]) begin
                        $display("Fail lcd.rs: expected %h, got %h and %h", exp_byte[8],
                                 hi_rs, lcd.rs);
                        value_errors++;
                    end
                end
            end
            e_prev = lcd.e;
        end
    end

    //******************************************************************
    // reset state and alive LED
    //******************************************************************

    initial led_done = 1'b0;

    always @(negedge CLK_I) begin
        if (RST_I || since_rst <= 1) begin
            if (busy !== 1'b0) begin
                $display("Fail o_busy: expected %h, got %h", 1'b0, busy);
                value_errors++;
            end
            if (lcd !== 6'h00) begin
                $display("Fail o_lcd: expected %h, got %h", 6'h00, lcd);
                value_errors++;
            end
        end
        if (RST_I) begin
            since_rst = 0;
        end else if (since_rst < led_span) begin
            // since_rst becomes the number of rising edges since the last
            // reset edge, so cycle 1 is the first one that counted
            since_rst++;
            // lit for the first half period, then dark for the same span
            if (alive_led !== (((since_rst / led_half) % 2) == 0)) begin
                $display("Fail o_alive_led: expected %h, got %h",
                         ((since_rst / led_half) % 2) == 0, alive_led);
                value_errors++;
            end
        end else begin
            led_done = 1'b1;
        end
    end

    //******************************************************************
    // timeout
    //******************************************************************

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge CLK_I);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the test did not finish", cycle_cnt);
        other_errors++;
        finish_run();
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/hd44780_pkg.sv
hdl/hd44780_nybble_sender.sv
hdl/hd44780_byte_sequencer.sv
hdl/hd44780_controller.sv
tb/hd44780_checker.sv
tb/hd44780_clkgen.sv
tb/hd44780_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the HD44780 testbench with Verilator and runs it
# exits with status 0 only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module hd44780_tb -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vhd44780_tb)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
